/* Bender.yml */
package:
  name: router_output_port

sources:
  - files:
      - logic/noc_flit_pkg.sv
      - logic/noc_port_pkg.sv
      - logic/flit_fifo.sv
      - logic/round_robin_arbiter.sv
      - logic/switch_output_stage.sv
      - logic/router_output_port.sv

  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/router_output_port_tb.sv

/* dv/tb_traffic.svh */
//****************************************
// traffic table, LFSR and compare task for the router port testbench,
// included inside the testbench module
//****************************************
`ifndef TB_TRAFFIC_SVH
`define TB_TRAFFIC_SVH

// how the sink drives out_full while a row is the latest one started
typedef enum logic [1:0]
{
    SINK_READY,
    SINK_RANDOM,
    SINK_STALL
} sink_mode_e;

// one table row: source port, packets to send, start cycle, sink behavior
typedef struct packed
{
    logic [2:0]  port;
    logic [3:0]  packets;
    logic [15:0] start;
    sink_mode_e  mode;
} stim_row_t;

localparam int NUM_ROWS     = 10;
// rows at cycle 0 load every buffer before the first grant
localparam int RR_PACKETS   = 10;
localparam int STALL_CYCLES = 40;

localparam logic [31:0] LFSR_SEED = 32'h5fcaa303;
localparam logic [31:0] LFSR_TAPS = 32'h80200003;

// rows sorted by start cycle
localparam stim_row_t STIM_TABLE [NUM_ROWS] = '{
    '{3'd0, 4'd2, 16'd0,   SINK_READY},
    '{3'd1, 4'd2, 16'd0,   SINK_READY},
    '{3'd2, 4'd2, 16'd0,   SINK_READY},
    '{3'd3, 4'd2, 16'd0,   SINK_READY},
    '{3'd4, 4'd2, 16'd0,   SINK_READY},
    '{3'd2, 4'd3, 16'd100, SINK_STALL},
    '{3'd0, 4'd3, 16'd200, SINK_RANDOM},
    '{3'd1, 4'd2, 16'd200, SINK_RANDOM},
    '{3'd3, 4'd3, 16'd200, SINK_RANDOM},
    '{3'd4, 4'd2, 16'd200, SINK_RANDOM}
};

// galois form, one step per bit used
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = state >> 1;
    if (state[0])
        shifted = shifted ^ LFSR_TAPS;
    return shifted;
endfunction

// source in 7:5, packet number in 4:2, flit index in 1:0
function automatic flit_word_t make_flit(input int port, input int packet, input int index);
    return {port[2:0], packet[2:0], index[1:0]};
endfunction

task automatic check_equal(input int actual, input int expected, input string what);
    check_count++;
    if (actual != expected)
    begin
        error_count++;
        $display("[FAIL] %0t: %s, got %0d expected %0d", $time, what, actual, expected);
    end
endtask

`endif

/* dv/router_output_port_tb.sv */
//****************************************
// testbench for the router output port; table-driven packet writers,
// a random or stalling sink and an in-order packet scoreboard
//****************************************
`timescale 1ns/100ps
`default_nettype none

module router_output_port_tb
    import noc_flit_pkg::*;
    import noc_port_pkg::*;
;

    localparam int PACKET_FLITS = 4;
    localparam int CLK_HALF     = 50;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 3;

    logic       clk;
    logic       reset;
    flit_link_t in_link [NUM_PORTS];
    port_vec_t  in_full;
    flit_link_t out_link;
    logic       out_full;

    logic       running = 1'b0;
    int         cycle_count = 0;
    int         timeout_limit = 0;
    int         total_flits = 0;
    int         check_count = 0;
    int         error_count = 0;

    // scoreboard state
    int         expected_pkts [NUM_PORTS];
    int         next_pkt [NUM_PORTS];
    int         rx_flits = 0;
    int         rx_packets = 0;
    int         flit_pos = 0;
    int         cur_src = 0;
    int         cur_pkt = 0;
    logic       prev_write = 1'b0;
    logic       prev_full = 1'b0;
    flit_link_t prev_link = '0;

    `include "tb_traffic.svh"

    router_output_port #(
        .PACKET_FLITS (PACKET_FLITS)
    ) u_router_output_port (
        .clk      (clk),
        .reset    (reset),
        .in_link  (in_link),
        .in_full  (in_full),
        .out_link (out_link),
        .out_full (out_full)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (running)
            cycle_count <= cycle_count + 1;
    end

    // one writer per input link, each walks the whole table
    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : writer
        flit_link_t drive;

        assign in_link[p] = drive;

        initial
        begin
            int pkt_num;
            int sent;
            int row_flits;
            pkt_num = 0;
            drive   = '0;
            wait (running);
            for (int r = 0; r < NUM_ROWS; r++)
            begin
                if (int'(STIM_TABLE[r].port) == p)
                begin
                    row_flits = int'(STIM_TABLE[r].packets) * PACKET_FLITS;
                    sent      = 0;
                    while (sent < row_flits)
                    begin
                        @(posedge clk);
                        #DRIVE_DELAY;
                        // wait for the start cycle, never write into a full buffer
                        if ((cycle_count >= int'(STIM_TABLE[r].start)) && !in_full[p])
                        begin
                            drive.write = 1'b1;
                            drive.flit  = make_flit(p, pkt_num, sent % PACKET_FLITS);
                            sent++;
                            if ((sent % PACKET_FLITS) == 0)
                                pkt_num++;
                        end
                        else
                            drive.write = 1'b0;
                    end
                    @(posedge clk);
                    #DRIVE_DELAY;
                    drive.write = 1'b0;
                end
            end
        end
    end

    // sink follows the latest row that has started
    initial
    begin
        logic [31:0] lfsr;
        int          row;
        int          stall_end;
        lfsr     = LFSR_SEED;
        out_full = 1'b0;
        wait (running);
        forever
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            row = 0;
            for (int r = 0; r < NUM_ROWS; r++)
            begin
                if (cycle_count >= int'(STIM_TABLE[r].start))
                    row = r;
            end
            stall_end = int'(STIM_TABLE[row].start) + STALL_CYCLES;
            case (STIM_TABLE[row].mode)
                SINK_RANDOM:
                begin
                    lfsr     = lfsr_next(lfsr);
                    out_full = lfsr[0];
                end
                SINK_STALL:
                begin
                    out_full = (cycle_count < stall_end);
                    // stalled port has been written past its two packets by now
                    if (cycle_count == stall_end - 1)
                        check_equal(in_full[STIM_TABLE[row].port], 1, "in_full under stall");
                end
                default:
                    out_full = 1'b0;
            endcase
        end
    end

    task automatic score_flit(input flit_word_t flit);
        int src;
        int pkt;
        int idx;
        src = int'(flit[7:5]);
        pkt = int'(flit[4:2]);
        idx = int'(flit[1:0]);
        rx_flits++;
        check_equal(idx, flit_pos, "flit index within packet");
        if (flit_pos == 0)
        begin
            cur_src = src;
            cur_pkt = pkt;
            check_equal(src < NUM_PORTS, 1, "source field in range");
            if (rx_packets < RR_PACKETS)
                check_equal(src, rx_packets % NUM_PORTS, "round-robin source order");
            if (src < NUM_PORTS)
                check_equal(pkt, next_pkt[src] % 8, "packet order of source");
        end
        else
        begin
            check_equal(src, cur_src, "source changed inside packet");
            check_equal(pkt, cur_pkt, "packet number changed inside packet");
        end
        flit_pos++;
        if (flit_pos == PACKET_FLITS)
        begin
            flit_pos = 0;
            rx_packets++;
            if (cur_src < NUM_PORTS)
                next_pkt[cur_src]++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (running)
        begin
            if (prev_write && prev_full)
                check_equal(out_link, prev_link, "out_link moved while out_full high");
            if (out_link.write && !out_full)
                score_flit(out_link.flit);
            prev_write = out_link.write;
            prev_full  = out_full;
            prev_link  = out_link;
        end
    end

    initial
    begin
        wait (running);
        wait (cycle_count >= timeout_limit);
        $display("error: run timed out after %0d cycles, %0d of %0d flits received",
                 cycle_count, rx_flits, total_flits);
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        reset = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            expected_pkts[p] = 0;
            next_pkt[p]      = 0;
        end
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            total_flits += int'(STIM_TABLE[r].packets) * PACKET_FLITS;
            expected_pkts[STIM_TABLE[r].port] += int'(STIM_TABLE[r].packets);
        end
        timeout_limit = total_flits * 4 + 200;

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_equal(out_link.write, 0, "out_link.write in reset");
        check_equal(in_full, 0, "in_full in reset");
        @(posedge clk);
        #DRIVE_DELAY;
        reset   = 1'b0;
        running = 1'b1;
        @(negedge clk);
        check_equal(out_link.write, 0, "out_link.write after reset");
        check_equal(in_full, 0, "in_full after reset");

        wait (rx_flits >= total_flits);
        // extra cycles let a duplicated flit show up
        repeat (20) @(posedge clk);
        @(negedge clk);
        check_equal(rx_flits, total_flits, "flits received against flits written");
        check_equal(flit_pos, 0, "partial packet at end");
        for (int p = 0; p < NUM_PORTS; p++)
            check_equal(next_pkt[p], expected_pkts[p], $sformatf("packets from port %0d", p));
        check_equal(out_link.write, 0, "out_link.write when drained");
        check_equal(in_full, 0, "in_full when drained");

        $display("checks %0d, errors %0d, flits %0d of %0d, packets %0d",
                 check_count, error_count, rx_flits, total_flits, rx_packets);
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/flit_fifo.sv */
//****************************************
// input flit buffer for one link, two packets deep;
// flags the arbiter once a whole packet is stored
//****************************************
`timescale 1ns/100ps
`default_nettype none

module flit_fifo
    import noc_flit_pkg::*;
#(
    parameter int PACKET_FLITS = 8
)
(
    input  logic       clk,
    input  logic       reset,
    input  flit_link_t wr_link,
    output logic       full,
    input  logic       pop,
    output flit_word_t head,
    output logic       packet_ready
);

    localparam int DEPTH = 2 * PACKET_FLITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] fifo_ptr_t;
    typedef logic [CNT_W-1:0] fifo_cnt_t;

    localparam fifo_ptr_t LAST_SLOT = fifo_ptr_t'(DEPTH - 1);

    flit_word_t mem [DEPTH];
    fifo_ptr_t  wr_ptr;
    fifo_ptr_t  rd_ptr;
    fifo_cnt_t  count;
    logic       push;
    logic       take;

    // depth need not be a power of two
    function automatic fifo_ptr_t next_ptr(input fifo_ptr_t ptr);
        return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
    endfunction

    assign push = wr_link.write && !full;
    // never pop an empty buffer
    assign take = pop && (count != '0);

    assign full         = (count == fifo_cnt_t'(DEPTH));
    assign packet_ready = (count >= fifo_cnt_t'(PACKET_FLITS));
    assign head         = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= wr_link.flit;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (take)
                rd_ptr <= next_ptr(rd_ptr);
            if (push && !take)
                count <= count + 1'b1;
            else if (take && !push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/noc_flit_pkg.sv */
//****************************************
// flit word and link transfer types, shared by the buffers,
// the output stage and the top level of the router port
//****************************************
`default_nettype none

package noc_flit_pkg;

    // width of one flit on every link
    localparam int FLIT_WIDTH = 8;

    typedef logic [FLIT_WIDTH-1:0] flit_word_t;

    // one link transfer
    // write marks a valid flit in this cycle, the link's full signal runs back separately
    typedef struct packed
    {
        logic       write;
        flit_word_t flit;
    } flit_link_t;

endpackage

`default_nettype wire

/* logic/noc_port_pkg.sv */
//****************************************
// port numbering, crossbar select codes and arbiter states
// for the five-input router output port
//****************************************
`default_nettype none

package noc_port_pkg;

    // local, north, south, east, west
    localparam int NUM_PORTS = 5;

    // bit 0 local, 1 north, 2 south, 3 east, 4 west
    typedef logic [NUM_PORTS-1:0] port_vec_t;

    // crossbar select, also used as a port index
    typedef logic [2:0] port_sel_t;

    localparam port_sel_t SEL_LOCAL = 3'd0;
    localparam port_sel_t SEL_NORTH = 3'd1;
    localparam port_sel_t SEL_SOUTH = 3'd2;
    localparam port_sel_t SEL_EAST  = 3'd3;
    localparam port_sel_t SEL_WEST  = 3'd4;
    localparam port_sel_t SEL_NONE  = 3'd5;

    // packet arbiter FSM
    typedef enum logic [1:0]
    {
        ARB_IDLE,
        ARB_NOLOAD,
        ARB_ARBITRATE,
        ARB_SENDING
    } arb_state_e;

endpackage

`default_nettype wire

/* logic/round_robin_arbiter.sv */
//****************************************
// packet-level round-robin arbiter; holds a grant for a whole packet
// and steers the crossbar and buffer pops of the output port
//****************************************
`timescale 1ns/100ps
`default_nettype none

module round_robin_arbiter
    import noc_port_pkg::*;
#(
    parameter int PACKET_FLITS = 8
)
(
    input  logic      clk,
    input  logic      reset,
    input  port_vec_t request,
    input  logic      destination_full,
    output port_vec_t grant_vec,
    output port_sel_t crossbar_control,
    output logic      write_request
);

    localparam int CNT_W = $clog2(PACKET_FLITS);

    typedef logic [CNT_W-1:0] flit_cnt_t;

    localparam flit_cnt_t LAST_FLIT = flit_cnt_t'(PACKET_FLITS - 1);

    arb_state_e state;
    arb_state_e next_state;
    port_sel_t  rr_pointer;
    port_vec_t  grant_reg;
    port_vec_t  arb_request;
    port_vec_t  shifted_request;
    port_vec_t  shifted_grant;
    port_vec_t  unrotated_grant;
    flit_cnt_t  flit_count;
    logic       last_flit;
    logic       load_grant;
    logic       update_pointer;

    // while a packet is open the granted buffer still counts the flit being popped
    // so its request bit is masked out of the next arbitration
    assign arb_request = (state == ARB_IDLE) ? request : (request & ~grant_reg);

    // rotate so that the pointer position has the highest priority
    always_comb
    begin
        int idx;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            idx = i + int'(rr_pointer);
            if (idx >= NUM_PORTS)
                idx = idx - NUM_PORTS;
            shifted_request[i] = arb_request[idx];
        end
    end

    // fixed priority, lowest bit wins
    always_comb
    begin
        shifted_grant = '0;
        for (int i = NUM_PORTS - 1; i >= 0; i--)
        begin
            if (shifted_request[i])
            begin
                shifted_grant    = '0;
                shifted_grant[i] = 1'b1;
            end
        end
    end

    // undo the rotation
    always_comb
    begin
        int idx;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            idx = i + int'(rr_pointer);
            if (idx >= NUM_PORTS)
                idx = idx - NUM_PORTS;
            unrotated_grant[idx] = shifted_grant[i];
        end
    end

    assign write_request  = (state != ARB_IDLE) && !destination_full;
    assign last_flit      = (state == ARB_SENDING) && write_request && (flit_count == LAST_FLIT);
    // next grant is taken straight from the combinational result at the last flit
    assign load_grant     = ((state == ARB_IDLE) && (|request)) || last_flit;
    assign update_pointer = (state == ARB_NOLOAD) || (state == ARB_ARBITRATE);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            grant_reg <= '0;
        else if (load_grant)
            grant_reg <= unrotated_grant;
    end

    // pointer moves one past the port that now owns the output
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            rr_pointer <= SEL_LOCAL;
        else if (update_pointer)
        begin
            for (int i = 0; i < NUM_PORTS; i++)
            begin
                if (grant_reg[i])
                    rr_pointer <= (i == NUM_PORTS - 1) ? SEL_LOCAL : port_sel_t'(i + 1);
            end
        end
    end

    // flits sent in the current packet
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            flit_count <= '0;
        else if (last_flit)
            flit_count <= '0;
        else if (write_request)
            flit_count <= flit_count + 1'b1;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= ARB_IDLE;
        else
            state <= next_state;
    end

    // NOLOAD is entered from idle, ARBITRATE straight from a finished packet
    always_comb
    begin
        next_state = state;
        case (state)
            ARB_IDLE:
                if (|request)
                    next_state = ARB_NOLOAD;
            ARB_NOLOAD, ARB_ARBITRATE:
                if (write_request)
                    next_state = ARB_SENDING;
            ARB_SENDING:
                if (last_flit)
                    next_state = (|arb_request) ? ARB_ARBITRATE : ARB_IDLE;
            default:
                next_state = ARB_IDLE;
        endcase
    end

    // in idle the fresh result is shown before it is registered
    assign grant_vec = (state == ARB_IDLE) ? unrotated_grant : grant_reg;

    always_comb
    begin
        case (grant_vec)
            5'b00001: crossbar_control = SEL_LOCAL;
            5'b00010: crossbar_control = SEL_NORTH;
            5'b00100: crossbar_control = SEL_SOUTH;
            5'b01000: crossbar_control = SEL_EAST;
            5'b10000: crossbar_control = SEL_WEST;
            default:  crossbar_control = SEL_NONE;
        endcase
    end

endmodule

`default_nettype wire

/* logic/router_output_port.sv */
//****************************************
// one output port of a five-port mesh router;
// buffers five input links and forwards whole packets round robin
//****************************************
`timescale 1ns/100ps
`default_nettype none

module router_output_port
    import noc_flit_pkg::*;
    import noc_port_pkg::*;
#(
    parameter int PACKET_FLITS = 8
)
(
    input  logic       clk,
    input  logic       reset,
    input  flit_link_t in_link [NUM_PORTS],
    output port_vec_t  in_full,
    output flit_link_t out_link,
    input  logic       out_full
);

    port_vec_t  request;
    port_vec_t  grant_vec;
    port_vec_t  pop;
    port_sel_t  crossbar_control;
    flit_word_t heads [NUM_PORTS];
    logic       write_request;
    logic       stage_full;

    // one buffer per input link
    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : u_fifo
        flit_fifo #(
            .PACKET_FLITS (PACKET_FLITS)
        ) u_flit_fifo (
            .clk          (clk),
            .reset        (reset),
            .wr_link      (in_link[p]),
            .full         (in_full[p]),
            .pop          (pop[p]),
            .head         (heads[p]),
            .packet_ready (request[p])
        );
    end

    round_robin_arbiter #(
        .PACKET_FLITS (PACKET_FLITS)
    ) u_arbiter (
        .clk              (clk),
        .reset            (reset),
        .request          (request),
        .destination_full (stage_full),
        .grant_vec        (grant_vec),
        .crossbar_control (crossbar_control),
        .write_request    (write_request)
    );

    switch_output_stage #(
        .PACKET_FLITS (PACKET_FLITS)
    ) u_output (
        .clk              (clk),
        .reset            (reset),
        .heads            (heads),
        .crossbar_control (crossbar_control),
        .grant_vec        (grant_vec),
        .write_request    (write_request),
        .pop              (pop),
        .stage_full       (stage_full),
        .out_link         (out_link),
        .out_full         (out_full)
    );

endmodule

`default_nettype wire

/* logic/switch_output_stage.sv */
//****************************************
// crossbar mux and two-entry output skid buffer;
// pops the granted input buffer for each flit sent
//****************************************
`timescale 1ns/100ps
`default_nettype none

module switch_output_stage
    import noc_flit_pkg::*;
    import noc_port_pkg::*;
#(
    parameter int PACKET_FLITS = 8
)
(
    input  logic       clk,
    input  logic       reset,
    input  flit_word_t heads [NUM_PORTS],
    input  port_sel_t  crossbar_control,
    input  port_vec_t  grant_vec,
    input  logic       write_request,
    output port_vec_t  pop,
    output logic       stage_full,
    output flit_link_t out_link,
    input  logic       out_full
);

    flit_word_t xbar_flit;
    flit_word_t slot0;
    flit_word_t slot1;
    logic [1:0] used;
    logic       drain;

    // crossbar select stays fixed for the whole packet
    always_comb
    begin
        xbar_flit = '0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (crossbar_control == port_sel_t'(i))
                xbar_flit = heads[i];
        end
    end

    assign pop = grant_vec & {NUM_PORTS{write_request}};

    // registered count and out_full only, no path from the pop
    assign stage_full = (used == 2'd2) || ((used == 2'd1) && out_full);
    assign drain      = (used != 2'd0) && !out_full;
    assign out_link   = '{write: (used != 2'd0), flit: slot0};

    // slot0 is always the flit on the link
    always_ff @(posedge clk)
    begin
        case ({write_request, drain})
            2'b10:
                if (used == 2'd0)
                    slot0 <= xbar_flit;
                else
                    slot1 <= xbar_flit;
            2'b01:
                slot0 <= slot1;
            2'b11:
                if (used == 2'd1)
                    slot0 <= xbar_flit;
                else
                begin
                    slot0 <= slot1;
                    slot1 <= xbar_flit;
                end
            default:
                ;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            used <= 2'd0;
        else if (write_request && !drain)
            used <= used + 2'd1;
        else if (drain && !write_request)
            used <= used - 2'd1;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+dv
logic/noc_flit_pkg.sv
logic/noc_port_pkg.sv
logic/flit_fifo.sv
logic/round_robin_arbiter.sv
logic/switch_output_stage.sv
logic/router_output_port.sv
dv/router_output_port_tb.sv
